/* ccip_checker.f */
+incdir+testbench
hdl/ccip_check_pkg.sv
hdl/ccip_tx_sampler.sv
hdl/c0_read_checker.sv
hdl/c1_mcl_checker.sv
hdl/mmio_rsp_tracker.sv
hdl/error_collector.sv
hdl/ccip_checker.sv
testbench/tb_ccip_checker.sv

/* Makefile */
# Verilator build for the CCI-P checker testbench

VERILATOR ?= verilator
TOP       := tb_ccip_checker
FILELIST  := ccip_checker.f
OBJ_DIR   := obj_dir
LINTFLAGS := --lint-only --timing --assert
SIMFLAGS  := --binary --timing --assert -j 0
PASS_MSG  := Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

# Pass only if the pass message shows in the output
sim:
	$(VERILATOR) $(SIMFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* testbench/tb_vectors.svh */
/*
 * Stimulus table for the checker testbench, included inside its module.
 * Each add_row is one driven cycle: test name, inputs, and the error_code
 * expected two cycles later. expect_sums adds summary checks to the last row.
 */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

task automatic load_vectors();
   // Legal read and 4-line write
   add_row("rd_1cl_legal", read_req(1, 42'h100), '0);
   add_row("wr_4cl_line0", write_req(4, 1'b1, 42'h200, 16'h0011), '0);
   add_row("wr_4cl_line1", write_req(4, 1'b0, 42'h201, 16'h0011), '0);
   add_row("wr_4cl_line2", write_req(4, 1'b0, 42'h202, 16'h0011), '0);
   add_row("wr_4cl_line3", write_req(4, 1'b0, 42'h203, 16'h0011), '0);
   expect_sums(1'b0, 1'b0);
   // Channel 0 rules
   // Zero address is warning class
   add_row("rd_zero_addr", read_req(1, 42'h0), bit_of(ccip_check_pkg::C0_ADDR_ZERO));
   expect_sums(1'b0, 1'b1);
   add_row("rd_3cl", read_req(3, 42'h300), bit_of(ccip_check_pkg::C0_3CL));
   expect_sums(1'b1, 1'b1);
   add_row("rd_align2", read_req(2, 42'h301), bit_of(ccip_check_pkg::C0_ALIGN2));
   add_row("rd_align4", read_req(4, 42'h302), bit_of(ccip_check_pkg::C0_ALIGN4));
   add_row("rd_write_type", as_write_type(read_req(1, 42'h300)),
           bit_of(ccip_check_pkg::C0_INVALID_REQTYPE));
   add_row("rd_overflow", with_c0_full(read_req(1, 42'h100)),
           bit_of(ccip_check_pkg::C0_OVERFLOW));
   // Channel 1 single and multi-line rules
   add_row("wr_no_sop", write_req(1, 1'b0, 42'h400, 16'h0000),
           bit_of(ccip_check_pkg::C1_SOP_NOT_SET));
   add_row("wr_fence_sop", fence_req(1'b1), bit_of(ccip_check_pkg::C1_WRFENCE_SOP));
   add_row("mcl_line0", write_req(4, 1'b1, 42'h500, 16'h0022), '0);
   add_row("mcl_sop_again", write_req(4, 1'b1, 42'h501, 16'h0022),
           bit_of(ccip_check_pkg::C1_SOP_SET_MCL));
   add_row("mcl_bad_addr", write_req(4, 1'b0, 42'h503, 16'h0022),
           bit_of(ccip_check_pkg::C1_UNEXP_ADDR));
   add_row("mcl_fence", fence_req(1'b0), bit_of(ccip_check_pkg::C1_WRFENCE_IN_MCL));
   add_row("mcl_new_mdata", write_req(4, 1'b0, 42'h503, 16'h0023),
           bit_of(ccip_check_pkg::C1_UNEXP_MDATA));
   // Soft reset straight after the mdata warning
   add_row("rst_c0", in_soft_reset(read_req(1, 42'h100)),
           bit_of(ccip_check_pkg::C0_RESET_IGNORED));
   add_row("rst_c1", in_soft_reset(write_req(1, 1'b1, 42'h400, 16'h0000)),
           bit_of(ccip_check_pkg::C1_RESET_IGNORED));
   add_row("rst_mmio_rsp", in_soft_reset(mmio_response(9'd3)),
           bit_of(ccip_check_pkg::MMIO_RESET_IGNORED));
   add_idle("post_soft_reset", 1);
   // MMIO tracking
   add_row("mmio_unsolicited", mmio_response(9'd5), bit_of(ccip_check_pkg::MMIO_UNSOLICITED));
   add_row("mmio_req", mmio_request(9'd6), '0);
   add_idle("mmio_wait", 4);
   add_row("mmio_rsp_in_time", mmio_response(9'd6), '0);
   add_row("mmio_req_lost", mmio_request(9'd7), '0);
   // Timeout shows from the 17th row after the request
   add_idle("mmio_before_limit", 16);
   add_row("mmio_timeout", idle_beat(), bit_of(ccip_check_pkg::MMIO_TIMEOUT));
   add_row("mmio_late_rsp", mmio_response(9'd7), bit_of(ccip_check_pkg::MMIO_TIMEOUT));
   add_idle("mmio_cleared", 1);
endtask

`endif

/* testbench/tb_ccip_checker.sv */
/*
 * Testbench for the CCI-P protocol checker.
 * Drives one table row per clock, 1 ns after the rising edge, and compares
 * error_code two cycles later. Rows can also ask for the sticky summaries.
 * The row table is built by tb_vectors.svh. Stops at the first mismatch.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_ccip_checker;

   // One driven cycle of DUT inputs
   typedef struct packed {
      logic                                 soft_reset;
      logic                                 c0_valid;
      ccip_check_pkg::c0_req_hdr_t          c0_hdr;
      logic                                 c0_realfull;
      logic                                 c1_valid;
      ccip_check_pkg::c1_req_hdr_t          c1_hdr;
      logic                                 c1_realfull;
      logic                                 mmio_req_valid;
      logic [ccip_check_pkg::TID_WIDTH-1:0] mmio_req_tid;
      logic                                 mmio_rsp_valid;
      logic [ccip_check_pkg::TID_WIDTH-1:0] mmio_rsp_tid;
   } stim_t;

   // Expected results of one row
   typedef struct packed {
      ccip_check_pkg::err_vec_t code;
      logic                     chk_sum;
      logic                     error_seen;
      logic                     warn_seen;
   } expect_t;

   logic                                 clk = 1'b0;
   logic                                 ase_reset;
   logic                                 soft_reset;
   logic                                 c0_valid;
   ccip_check_pkg::c0_req_hdr_t          c0_hdr;
   logic                                 c1_valid;
   ccip_check_pkg::c1_req_hdr_t          c1_hdr;
   logic                                 c0_realfull;
   logic                                 c1_realfull;
   logic                                 mmio_req_valid;
   logic [ccip_check_pkg::TID_WIDTH-1:0] mmio_req_tid;
   logic                                 mmio_rsp_valid;
   logic [ccip_check_pkg::TID_WIDTH-1:0] mmio_rsp_tid;
   ccip_check_pkg::err_vec_t             error_code;
   logic                                 error_seen;
   logic                                 warn_seen;

   // Row table, one entry per driven cycle
   string   row_name [$];
   stim_t   row_stim [$];
   expect_t row_exp  [$];
   int      cycles      = 0;
   int      cycle_limit = 0;

   ccip_checker #(
      .MMIO_TIMEOUT (16),
      .TRACK_TIDS   (16)
   ) u_ccip_checker (
      .clk, .ase_reset, .soft_reset,
      .c0_valid, .c0_hdr, .c1_valid, .c1_hdr,
      .c0_realfull, .c1_realfull,
      .mmio_req_valid, .mmio_req_tid, .mmio_rsp_valid, .mmio_rsp_tid,
      .error_code, .error_seen, .warn_seen
   );

   // 8 ns period
   always #4 clk = ~clk;

   // Watchdog sized from the table length
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycle_limit > 0 && cycles >= cycle_limit) begin
         $display("Run did not finish within %0d cycles", cycle_limit);
         $display("Simulation finished: FAIL");
         $fatal(1, "Watchdog expired");
      end
   end

   function automatic ccip_check_pkg::err_vec_t bit_of(ccip_check_pkg::sniff_code_e c);
      ccip_check_pkg::err_vec_t v;
      v    = '0;
      v[c] = 1'b1;
      return v;
   endfunction

   function automatic stim_t idle_beat();
      return '0;
   endfunction

   // RDLINE_S read with length in lines
   function automatic stim_t read_req(int lines,
                                      logic [ccip_check_pkg::CL_ADDR_WIDTH-1:0] addr);
      stim_t s;
      s                 = '0;
      s.c0_valid        = 1'b1;
      s.c0_hdr.req_type = ccip_check_pkg::REQ_RDLINE_S;
      s.c0_hdr.cl_len   = ccip_check_pkg::cl_len_e'(lines[1:0] - 2'd1);
      s.c0_hdr.address  = addr;
      return s;
   endfunction

   // WRLINE_I write line
   function automatic stim_t write_req(int lines, logic sop,
                                       logic [ccip_check_pkg::CL_ADDR_WIDTH-1:0] addr,
                                       logic [ccip_check_pkg::MDATA_WIDTH-1:0] mdata);
      stim_t s;
      s                 = '0;
      s.c1_valid        = 1'b1;
      s.c1_hdr.req_type = ccip_check_pkg::REQ_WRLINE_I;
      s.c1_hdr.cl_len   = ccip_check_pkg::cl_len_e'(lines[1:0] - 2'd1);
      s.c1_hdr.sop      = sop;
      s.c1_hdr.address  = addr;
      s.c1_hdr.mdata    = mdata;
      return s;
   endfunction

   // Fences are always single-line
   function automatic stim_t fence_req(logic sop);
      stim_t s;
      s                 = '0;
      s.c1_valid        = 1'b1;
      s.c1_hdr.req_type = ccip_check_pkg::REQ_WRFENCE;
      s.c1_hdr.sop      = sop;
      return s;
   endfunction

   function automatic stim_t mmio_request(logic [ccip_check_pkg::TID_WIDTH-1:0] tid);
      stim_t s;
      s                = '0;
      s.mmio_req_valid = 1'b1;
      s.mmio_req_tid   = tid;
      return s;
   endfunction

   function automatic stim_t mmio_response(logic [ccip_check_pkg::TID_WIDTH-1:0] tid);
      stim_t s;
      s                = '0;
      s.mmio_rsp_valid = 1'b1;
      s.mmio_rsp_tid   = tid;
      return s;
   endfunction

   function automatic stim_t with_c0_full(stim_t s);
      stim_t r;
      r             = s;
      r.c0_realfull = 1'b1;
      return r;
   endfunction

   // Write code on the read channel
   function automatic stim_t as_write_type(stim_t s);
      stim_t r;
      r                 = s;
      r.c0_hdr.req_type = ccip_check_pkg::REQ_WRLINE_I;
      return r;
   endfunction

   function automatic stim_t in_soft_reset(stim_t s);
      stim_t r;
      r            = s;
      r.soft_reset = 1'b1;
      return r;
   endfunction

   task automatic add_row(string name, stim_t s, ccip_check_pkg::err_vec_t code);
      expect_t e;
      e.code       = code;
      e.chk_sum    = 1'b0;
      e.error_seen = 1'b0;
      e.warn_seen  = 1'b0;
      row_name.push_back(name);
      row_stim.push_back(s);
      row_exp.push_back(e);
   endtask

   task automatic add_idle(string name, int n);
      for (int i = 0; i < n; i++) begin
         add_row(name, idle_beat(), '0);
      end
   endtask

   // Summary check on the last row added
   task automatic expect_sums(logic err, logic warn);
      expect_t e;
      e            = row_exp[row_exp.size() - 1];
      e.chk_sum    = 1'b1;
      e.error_seen = err;
      e.warn_seen  = warn;
      row_exp[row_exp.size() - 1] = e;
   endtask

   `include "tb_vectors.svh"

   task automatic drive_inputs(stim_t s);
      soft_reset     = s.soft_reset;
      c0_valid       = s.c0_valid;
      c0_hdr         = s.c0_hdr;
      c0_realfull    = s.c0_realfull;
      c1_valid       = s.c1_valid;
      c1_hdr         = s.c1_hdr;
      c1_realfull    = s.c1_realfull;
      mmio_req_valid = s.mmio_req_valid;
      mmio_req_tid   = s.mmio_req_tid;
      mmio_rsp_valid = s.mmio_rsp_valid;
      mmio_rsp_tid   = s.mmio_rsp_tid;
   endtask

   task automatic check_err_vec(string name, ccip_check_pkg::err_vec_t exp,
                                ccip_check_pkg::err_vec_t act);
      if (exp !== act) begin
         $display("ERROR %s: expected %h, actual %h", name, exp, act);
         $display("Simulation finished: FAIL");
         $fatal(1, "error_code mismatch");
      end
   endtask

   task automatic check_bit(string name, logic exp, logic act);
      if (exp !== act) begin
         $display("ERROR %s: expected %b, actual %b", name, exp, act);
         $display("Simulation finished: FAIL");
         $fatal(1, "Summary mismatch");
      end
   endtask

   task automatic check_row(int idx);
      check_err_vec(row_name[idx], row_exp[idx].code, error_code);
      if (row_exp[idx].chk_sum) begin
         check_bit({row_name[idx], " error_seen"}, row_exp[idx].error_seen, error_seen);
         check_bit({row_name[idx], " warn_seen"}, row_exp[idx].warn_seen, warn_seen);
      end
   endtask

   initial begin
      int n_rows;
      ase_reset = 1'b1;
      drive_inputs(idle_beat());
      load_vectors();
      n_rows      = row_name.size();
      cycle_limit = n_rows + 64;
      repeat (5) @(posedge clk);
      #1;
      ase_reset = 1'b0;
      check_err_vec("after_reset", '0, error_code);
      check_bit("after_reset error_seen", 1'b0, error_seen);
      check_bit("after_reset warn_seen", 1'b0, warn_seen);
      // Row i is driven while row i-2 shows at the output
      for (int i = 0; i < n_rows + 2; i++) begin
         @(posedge clk);
         #1;
         if (i >= 2) begin
            check_row(i - 2);
         end
         if (i < n_rows) begin
            drive_inputs(row_stim[i]);
         end else begin
            drive_inputs(idle_beat());
         end
      end
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

`default_nettype wire

/* hdl/ccip_checker.sv */
/*
 * CCI-P protocol checker top level.
 * Passive observer of the accelerator request channels and MMIO traffic.
 * A violation seen at one edge shows in error_code two edges later.
 */
`timescale 1ns/1ps
`default_nettype none

module ccip_checker #(
   parameter int MMIO_TIMEOUT = 512,
   parameter int TRACK_TIDS   = 2 ** ccip_check_pkg::TID_WIDTH
) (
   input  logic                                 clk,
   input  logic                                 ase_reset,
   input  logic                                 soft_reset,
   input  logic                                 c0_valid,
   input  ccip_check_pkg::c0_req_hdr_t          c0_hdr,
   input  logic                                 c1_valid,
   input  ccip_check_pkg::c1_req_hdr_t          c1_hdr,
   input  logic                                 c0_realfull,
   input  logic                                 c1_realfull,
   input  logic                                 mmio_req_valid,
   input  logic [ccip_check_pkg::TID_WIDTH-1:0] mmio_req_tid,
   input  logic                                 mmio_rsp_valid,
   input  logic [ccip_check_pkg::TID_WIDTH-1:0] mmio_rsp_tid,
   output ccip_check_pkg::err_vec_t             error_code,
   output logic                                 error_seen,
   output logic                                 warn_seen
);

   ccip_check_pkg::tx_beat_t beat;
   logic                     beat_in_reset;
   ccip_check_pkg::err_vec_t sampler_flags;
   ccip_check_pkg::err_vec_t c0_flags;
   ccip_check_pkg::err_vec_t c1_flags;
   ccip_check_pkg::err_vec_t mmio_flags;

   ccip_tx_sampler u_tx_sampler (
      .clk, .ase_reset, .soft_reset,
      .c0_valid, .c0_hdr, .c1_valid, .c1_hdr,
      .c0_realfull, .c1_realfull,
      .mmio_req_valid, .mmio_req_tid, .mmio_rsp_valid, .mmio_rsp_tid,
      .beat, .beat_in_reset,
      .flags (sampler_flags)
   );

   c0_read_checker u_c0_read_checker (
      .beat, .beat_in_reset,
      .flags (c0_flags)
   );

   c1_mcl_checker u_c1_mcl_checker (
      .clk, .ase_reset, .beat, .beat_in_reset,
      .flags (c1_flags)
   );

   mmio_rsp_tracker #(
      .MMIO_TIMEOUT (MMIO_TIMEOUT),
      .TRACK_TIDS   (TRACK_TIDS)
   ) u_mmio_rsp_tracker (
      .clk, .ase_reset, .beat, .beat_in_reset,
      .flags (mmio_flags)
   );

   // Masking follows the sampled beat so the flags and the mask line up
   error_collector u_error_collector (
      .clk, .ase_reset,
      .soft_reset (beat_in_reset),
      .sampler_flags, .c0_flags, .c1_flags, .mmio_flags,
      .error_code, .error_seen, .warn_seen
   );

endmodule

`default_nettype wire

/* hdl/error_collector.sv */
/*
 * Output stage of the checker.
 * ORs the flag vectors of the sampler and the three checkers into the
 * registered error code, keeping only the reset-ignored rules during soft
 * reset. Sticky error and warning summaries hold until the next hard reset.
 */
`timescale 1ns/1ps
`default_nettype none

module error_collector (
   input  logic                     clk,
   input  logic                     ase_reset,
   input  logic                     soft_reset,
   input  ccip_check_pkg::err_vec_t sampler_flags,
   input  ccip_check_pkg::err_vec_t c0_flags,
   input  ccip_check_pkg::err_vec_t c1_flags,
   input  ccip_check_pkg::err_vec_t mmio_flags,
   output ccip_check_pkg::err_vec_t error_code,
   output logic                     error_seen,
   output logic                     warn_seen
);

   // Rules that stay visible in soft reset
   localparam ccip_check_pkg::err_vec_t RST_IGN_MASK =
      (ccip_check_pkg::err_vec_t'(1) << ccip_check_pkg::C0_RESET_IGNORED) |
      (ccip_check_pkg::err_vec_t'(1) << ccip_check_pkg::C1_RESET_IGNORED) |
      (ccip_check_pkg::err_vec_t'(1) << ccip_check_pkg::MMIO_RESET_IGNORED);

   ccip_check_pkg::err_vec_t merged;
   ccip_check_pkg::err_vec_t code_nxt;

   assign merged   = sampler_flags | c0_flags | c1_flags | mmio_flags;
   assign code_nxt = soft_reset ? (merged & RST_IGN_MASK) : merged;

   always_ff @(posedge clk) begin
      if (ase_reset) begin
         error_code <= '0;
         error_seen <= 1'b0;
         warn_seen  <= 1'b0;
      end else begin
         error_code <= code_nxt;
         error_seen <= error_seen || |(code_nxt & ccip_check_pkg::FATAL_MASK);
         warn_seen  <= warn_seen || |(code_nxt & ~ccip_check_pkg::FATAL_MASK);
      end
   end

   // Each rule is owned by exactly one source
   a_disjoint_sources : assert property (@(posedge clk) disable iff (ase_reset)
      ((sampler_flags & (c0_flags | c1_flags | mmio_flags)) |
       (c0_flags & (c1_flags | mmio_flags)) | (c1_flags & mmio_flags)) == '0);

endmodule

`default_nettype wire

/* hdl/mmio_rsp_tracker.sv */
/*
 * MMIO read response tracking.
 * One active bit and one saturating age counter per tracked TID. A request
 * opens an entry, a response closes it. Responses to closed entries are
 * unsolicited, and an entry left open for MMIO_TIMEOUT cycles times out.
 */
`timescale 1ns/1ps
`default_nettype none

module mmio_rsp_tracker #(
   parameter int MMIO_TIMEOUT = 512,
   parameter int TRACK_TIDS   = 2 ** ccip_check_pkg::TID_WIDTH
) (
   input  logic                     clk,
   input  logic                     ase_reset,
   input  ccip_check_pkg::tx_beat_t beat,
   input  logic                     beat_in_reset,
   output ccip_check_pkg::err_vec_t flags
);

   localparam int IDX_W = (TRACK_TIDS > 1) ? $clog2(TRACK_TIDS) : 1;
   localparam int CNT_W = $clog2(MMIO_TIMEOUT + 1);

   logic             active [TRACK_TIDS];
   logic [CNT_W-1:0] age    [TRACK_TIDS];
   logic [IDX_W-1:0] req_idx;
   logic [IDX_W-1:0] rsp_idx;
   logic             any_expired;

   // Low TID bits select the entry
   assign req_idx = beat.mmio_req.tid[IDX_W-1:0];
   assign rsp_idx = beat.mmio_rsp.tid[IDX_W-1:0];

   always_comb begin
      any_expired = 1'b0;
      for (int i = 0; i < TRACK_TIDS; i++) begin
         any_expired |= active[i] && (age[i] == CNT_W'(MMIO_TIMEOUT));
      end
   end

   always_comb begin
      flags = '0;
      flags[ccip_check_pkg::MMIO_TIMEOUT] = any_expired;
      // Table state before this beat's request
      flags[ccip_check_pkg::MMIO_UNSOLICITED] =
         beat.mmio_rsp_valid && !beat_in_reset && !active[rsp_idx];
   end

   always_ff @(posedge clk) begin
      if (ase_reset || beat_in_reset) begin
         for (int i = 0; i < TRACK_TIDS; i++) begin
            active[i] <= 1'b0;
            age[i]    <= '0;
         end
      end else begin
         // Age stops at the limit
         for (int i = 0; i < TRACK_TIDS; i++) begin
            if (active[i] && (age[i] != CNT_W'(MMIO_TIMEOUT))) begin
               age[i] <= age[i] + 1'b1;
            end
         end
         if (beat.mmio_rsp_valid) begin
            active[rsp_idx] <= 1'b0;
         end
         // Same-cycle request to the same TID wins
         if (beat.mmio_req_valid) begin
            active[req_idx] <= 1'b1;
            age[req_idx]    <= '0;
         end
      end
   end

endmodule

`default_nettype wire

/* hdl/c1_mcl_checker.sv */
/*
 * Channel 1 write request rules.
 * A small FSM follows multi-line writes. In idle the first line is checked
 * for SOP, length, alignment and a zero address, and a 2CL or 4CL start
 * stores its base fields. Each later line is compared against that base.
 * Flags are combinational on the beat; the FSM moves at the next edge.
 */
`timescale 1ns/1ps
`default_nettype none

module c1_mcl_checker (
   input  logic                     clk,
   input  logic                     ase_reset,
   input  ccip_check_pkg::tx_beat_t beat,
   input  logic                     beat_in_reset,
   output ccip_check_pkg::err_vec_t flags
);

   // State value is the index of the line expected next
   typedef enum logic [1:0] {
      S_IDLE  = 2'd0,
      S_LINE1 = 2'd1,
      S_LINE2 = 2'd2,
      S_LINE3 = 2'd3
   } mcl_state_e;

   // Fields captured from the SOP line
   typedef struct packed {
      logic [1:0]                             addr_lo;
      ccip_check_pkg::vc_e                    vc;
      ccip_check_pkg::cl_len_e                cl_len;
      logic [ccip_check_pkg::MDATA_WIDTH-1:0] mdata;
      ccip_check_pkg::req_type_e              req_type;
   } mcl_base_t;

   ccip_check_pkg::c1_req_hdr_t hdr;
   mcl_state_e                  state;
   mcl_state_e                  state_nxt;
   mcl_base_t                   base;
   logic                        base_load;
   logic                        hdr_valid;
   logic                        is_write;
   logic                        is_fence;
   logic [1:0]                  line_k;
   logic [1:0]                  exp_addr_lo;

   assign hdr       = beat.c1_hdr;
   assign hdr_valid = beat.c1_valid && !beat_in_reset;
   assign is_fence  = (hdr.req_type == ccip_check_pkg::REQ_WRFENCE);
   assign is_write  = hdr.req_type inside {ccip_check_pkg::REQ_WRLINE_I,
                                           ccip_check_pkg::REQ_WRLINE_M,
                                           ccip_check_pkg::REQ_WRPUSH_I};
   assign line_k    = state;
   // Wraps modulo 4 like the line offset
   assign exp_addr_lo = base.addr_lo + line_k;

   always_comb begin
      flags     = '0;
      state_nxt = state;
      base_load = 1'b0;
      if (hdr_valid) begin
         flags[ccip_check_pkg::C1_INVALID_REQTYPE] = !is_write && !is_fence;
         flags[ccip_check_pkg::C1_WRFENCE_SOP]     = is_fence && hdr.sop;
         if (state == S_IDLE) begin
            if (is_write) begin
               flags[ccip_check_pkg::C1_SOP_NOT_SET] = !hdr.sop;
               flags[ccip_check_pkg::C1_3CL] = (hdr.cl_len == ccip_check_pkg::CL_LEN_3);
               flags[ccip_check_pkg::C1_ALIGN2] =
                  (hdr.cl_len == ccip_check_pkg::CL_LEN_2) && hdr.address[0];
               flags[ccip_check_pkg::C1_ALIGN4] =
                  (hdr.cl_len == ccip_check_pkg::CL_LEN_4) && (hdr.address[1:0] != 2'b00);
               flags[ccip_check_pkg::C1_ADDR_ZERO] = (hdr.address == '0);
               // Multi-line start
               if (hdr.sop && (hdr.cl_len inside {ccip_check_pkg::CL_LEN_2,
                                                  ccip_check_pkg::CL_LEN_4})) begin
                  base_load = 1'b1;
                  state_nxt = S_LINE1;
               end
            end
         end else if (is_fence) begin
            // Fence does not count as a line
            flags[ccip_check_pkg::C1_WRFENCE_IN_MCL] = 1'b1;
         end else begin
            flags[ccip_check_pkg::C1_SOP_SET_MCL]   = hdr.sop;
            flags[ccip_check_pkg::C1_UNEXP_ADDR]    = (hdr.address[1:0] != exp_addr_lo);
            flags[ccip_check_pkg::C1_UNEXP_CLLEN]   = (hdr.cl_len != base.cl_len);
            flags[ccip_check_pkg::C1_UNEXP_VC]      = (hdr.vc != base.vc);
            flags[ccip_check_pkg::C1_UNEXP_MDATA]   = (hdr.mdata != base.mdata);
            flags[ccip_check_pkg::C1_UNEXP_REQTYPE] = (hdr.req_type != base.req_type);
            // Length code equals the index of the last line
            if (line_k == base.cl_len) begin
               state_nxt = S_IDLE;
            end else begin
               state_nxt = mcl_state_e'(line_k + 2'd1);
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (ase_reset || beat_in_reset) begin
         state <= S_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   always_ff @(posedge clk) begin
      if (base_load) begin
         base <= '{addr_lo:  hdr.address[1:0],
                   vc:       hdr.vc,
                   cl_len:   hdr.cl_len,
                   mdata:    hdr.mdata,
                   req_type: hdr.req_type};
      end
   end

   // Never past the last line of the stored length
   a_line_in_range : assert property (@(posedge clk) disable iff (ase_reset)
      (state != S_IDLE) |-> (line_k <= base.cl_len));

endmodule

`default_nettype wire

/* hdl/c0_read_checker.sv */
/*
 * Channel 0 read request rules.
 * Purely combinational on the sampled beat. Flags bad request types,
 * the illegal 3-line length, 2-line and 4-line misalignment and a zero
 * address. Beats sampled during soft reset are left to the sampler.
 */
`timescale 1ns/1ps
`default_nettype none

module c0_read_checker (
   input  ccip_check_pkg::tx_beat_t beat,
   input  logic                     beat_in_reset,
   output ccip_check_pkg::err_vec_t flags
);

   ccip_check_pkg::c0_req_hdr_t hdr;
   logic                        is_read;

   assign hdr     = beat.c0_hdr;
   assign is_read = hdr.req_type inside {ccip_check_pkg::REQ_RDLINE_S,
                                         ccip_check_pkg::REQ_RDLINE_I};

   always_comb begin
      flags = '0;
      if (beat.c0_valid && !beat_in_reset) begin
         if (!is_read) begin
            // Wrong type hides the other rules
            flags[ccip_check_pkg::C0_INVALID_REQTYPE] = 1'b1;
         end else begin
            flags[ccip_check_pkg::C0_3CL] = (hdr.cl_len == ccip_check_pkg::CL_LEN_3);
            // 2CL needs an even line and 4CL a multiple of four
            flags[ccip_check_pkg::C0_ALIGN2] =
               (hdr.cl_len == ccip_check_pkg::CL_LEN_2) && hdr.address[0];
            flags[ccip_check_pkg::C0_ALIGN4] =
               (hdr.cl_len == ccip_check_pkg::CL_LEN_4) && (hdr.address[1:0] != 2'b00);
            flags[ccip_check_pkg::C0_ADDR_ZERO] = (hdr.address == '0);
         end
      end
   end

endmodule

`default_nettype wire

/* hdl/ccip_tx_sampler.sv */
/*
 * Input stage of the checker.
 * Registers every observed channel into one beat struct and derives the
 * overflow and ignored-reset flags from the raw inputs, so the flags line
 * up with the beat they belong to. Adds one cycle of latency.
 */
`timescale 1ns/1ps
`default_nettype none

module ccip_tx_sampler (
   input  logic                                 clk,
   input  logic                                 ase_reset,
   input  logic                                 soft_reset,
   input  logic                                 c0_valid,
   input  ccip_check_pkg::c0_req_hdr_t          c0_hdr,
   input  logic                                 c1_valid,
   input  ccip_check_pkg::c1_req_hdr_t          c1_hdr,
   input  logic                                 c0_realfull,
   input  logic                                 c1_realfull,
   input  logic                                 mmio_req_valid,
   input  logic [ccip_check_pkg::TID_WIDTH-1:0] mmio_req_tid,
   input  logic                                 mmio_rsp_valid,
   input  logic [ccip_check_pkg::TID_WIDTH-1:0] mmio_rsp_tid,
   output ccip_check_pkg::tx_beat_t             beat,
   output logic                                 beat_in_reset,
   output ccip_check_pkg::err_vec_t             flags
);

   ccip_check_pkg::err_vec_t flags_nxt;

   // Overflow and reset-ignored rules need only the raw strobes
   always_comb begin
      flags_nxt = '0;
      flags_nxt[ccip_check_pkg::C0_OVERFLOW]        = c0_valid && c0_realfull;
      flags_nxt[ccip_check_pkg::C1_OVERFLOW]        = c1_valid && c1_realfull;
      flags_nxt[ccip_check_pkg::C0_RESET_IGNORED]   = c0_valid && soft_reset;
      flags_nxt[ccip_check_pkg::C1_RESET_IGNORED]   = c1_valid && soft_reset;
      flags_nxt[ccip_check_pkg::MMIO_RESET_IGNORED] = mmio_rsp_valid && soft_reset;
   end

   always_ff @(posedge clk) begin
      // Headers and TIDs
      beat.c0_hdr       <= c0_hdr;
      beat.c1_hdr       <= c1_hdr;
      beat.mmio_req.tid <= mmio_req_tid;
      beat.mmio_rsp.tid <= mmio_rsp_tid;
      if (ase_reset) begin
         beat.c0_valid       <= 1'b0;
         beat.c1_valid       <= 1'b0;
         beat.mmio_req_valid <= 1'b0;
         beat.mmio_rsp_valid <= 1'b0;
         beat_in_reset       <= 1'b0;
         flags               <= '0;
      end else begin
         beat.c0_valid       <= c0_valid;
         beat.c1_valid       <= c1_valid;
         beat.mmio_req_valid <= mmio_req_valid;
         beat.mmio_rsp_valid <= mmio_rsp_valid;
         beat_in_reset       <= soft_reset;
         flags               <= flags_nxt;
      end
   end

   // A fence with SOP is single-line
   a_fence_sop_single : assert property (@(posedge clk) disable iff (ase_reset)
      c1_valid && c1_hdr.sop && (c1_hdr.req_type == ccip_check_pkg::REQ_WRFENCE)
      |-> (c1_hdr.cl_len == ccip_check_pkg::CL_LEN_1));

endmodule

`default_nettype wire

/* hdl/ccip_check_pkg.sv */
/*
 * Shared types for the CCI-P protocol checker.
 * Holds the request header layouts, the request-type and length encodings,
 * the bit position of every rule in the error vector, and the mask that
 * splits error-class rules from warning-class rules.
 * Every checker module refers to these by scoped name.
 */
`default_nettype none

package ccip_check_pkg;

   // Field widths
   localparam int CL_ADDR_WIDTH = 42;
   localparam int MDATA_WIDTH   = 16;
   localparam int TID_WIDTH     = 9;
   localparam int ERR_WIDTH     = 32;

   typedef enum logic [1:0] {
      VC_VA  = 2'b00,
      VC_VL0 = 2'b01,
      VC_VH0 = 2'b10,
      VC_VH1 = 2'b11
   } vc_e;

   // Encoded as number of lines minus one
   typedef enum logic [1:0] {
      CL_LEN_1 = 2'b00,
      CL_LEN_2 = 2'b01,
      CL_LEN_3 = 2'b10,
      CL_LEN_4 = 2'b11
   } cl_len_e;

   // Read and write codes share one space here
   typedef enum logic [3:0] {
      REQ_WRLINE_I = 4'h0,
      REQ_WRLINE_M = 4'h1,
      REQ_WRPUSH_I = 4'h2,
      REQ_WRFENCE  = 4'h4,
      REQ_RDLINE_S = 4'h8,
      REQ_RDLINE_I = 4'h9
   } req_type_e;

   // Channel 0 read header of 66 bits
   typedef struct packed {
      vc_e                      vc;
      cl_len_e                  cl_len;
      req_type_e                req_type;
      logic [CL_ADDR_WIDTH-1:0] address;
      logic [MDATA_WIDTH-1:0]   mdata;
   } c0_req_hdr_t;

   // Channel 1 write header of 67 bits
   typedef struct packed {
      vc_e                      vc;
      logic                     sop;
      cl_len_e                  cl_len;
      req_type_e                req_type;
      logic [CL_ADDR_WIDTH-1:0] address;
      logic [MDATA_WIDTH-1:0]   mdata;
   } c1_req_hdr_t;

   // MMIO request and response both carry only a TID
   typedef struct packed {
      logic [TID_WIDTH-1:0] tid;
   } mmio_hdr_t;

   // One observed cycle of all channels
   typedef struct packed {
      logic        c0_valid;
      c0_req_hdr_t c0_hdr;
      logic        c1_valid;
      c1_req_hdr_t c1_hdr;
      logic        mmio_req_valid;
      mmio_hdr_t   mmio_req;
      logic        mmio_rsp_valid;
      mmio_hdr_t   mmio_rsp;
   } tx_beat_t;

   // Bit position of each rule in the error vector
   typedef enum logic [$clog2(ERR_WIDTH)-1:0] {
      C0_INVALID_REQTYPE, C0_OVERFLOW, C0_ALIGN2, C0_ALIGN4,
      C0_RESET_IGNORED, C0_3CL, C0_ADDR_ZERO,
      C1_INVALID_REQTYPE, C1_OVERFLOW, C1_ALIGN2, C1_ALIGN4,
      C1_RESET_IGNORED, C1_UNEXP_VC, C1_UNEXP_MDATA, C1_UNEXP_ADDR,
      C1_UNEXP_CLLEN, C1_UNEXP_REQTYPE, C1_SOP_NOT_SET, C1_SOP_SET_MCL,
      C1_3CL, C1_WRFENCE_IN_MCL, C1_WRFENCE_SOP, C1_ADDR_ZERO,
      MMIO_TIMEOUT, MMIO_UNSOLICITED, MMIO_RESET_IGNORED
   } sniff_code_e;

   typedef logic [ERR_WIDTH-1:0] err_vec_t;

   // Warning class is listed; everything else is fatal
   localparam err_vec_t FATAL_MASK = ~(
      (err_vec_t'(1) << C0_ADDR_ZERO)     | (err_vec_t'(1) << C1_ADDR_ZERO)     |
      (err_vec_t'(1) << C0_RESET_IGNORED) | (err_vec_t'(1) << C1_RESET_IGNORED) |
      (err_vec_t'(1) << MMIO_RESET_IGNORED) |
      (err_vec_t'(1) << C1_UNEXP_VC)      | (err_vec_t'(1) << C1_UNEXP_MDATA)   |
      (err_vec_t'(1) << C1_UNEXP_CLLEN));

endpackage

`default_nettype wire
